// ==== common/uart_macros.svh ====
//////////////////////////////////////////////////////////////////////
// register map and constants of the 16550-style control block
//////////////////////////////////////////////////////////////////////

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// register addresses
`define UART_REG_RB_TR 3'd0  // rx buffer, DL low when DLAB
`define UART_REG_IE    3'd1  // IER, DL high when DLAB
`define UART_REG_II    3'd2  // IIR on read
`define UART_REG_LC    3'd3
`define UART_REG_MC    3'd4
`define UART_REG_LS    3'd5  // line status, reads zero here
`define UART_REG_MS    3'd6
`define UART_REG_SR    3'd7  // scratch

// line control
`define UART_LCR_RESET 8'h03  // 8 data bits, no parity, 1 stop
`define UART_LCR_DLAB  7

// interrupt enable and identification
`define UART_IER_MS    3
`define UART_IIR_NONE  4'h1
`define UART_IIR_MS    4'h0
`define UART_IIR_FIXED 4'hC

// modem side
`define UART_MODEM_LINES 4

`endif

// ==== common/uart_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// types shared by the UART register block and its testbench
// modem line bit i is line i of the monitors (0 cts .. 3 dcd)
//////////////////////////////////////////////////////////////////////

package uart_pkg;

  // bus side
  typedef logic [2:0]  reg_addr_t;  // register address
  typedef logic [7:0]  reg_data_t;  // register data byte

  // baud divisor latch and its down counter
  typedef logic [15:0] divisor_t;

  // four modem lines in MSR order
  // used for the pads, the line status and the delta flags
  typedef struct packed {
    logic dcd;  // bit 3
    logic ri;   // bit 2
    logic dsr;  // bit 1
    logic cts;  // bit 0
  } modem_lines_t;

  // modem control register, 5 bits
  typedef struct packed {
    logic loop;  // loopback enable
    logic out2;  // loops to dcd
    logic out1;  // loops to ri
    logic rts;   // rts pad, loops to cts
    logic dtr;   // dtr pad, loops to dsr
  } mcr_t;

endpackage

// ==== modem/modem_line_monitor.sv ====
//////////////////////////////////////////////////////////////////////
// LINE 0..3 is cts, dsr, ri, dcd; pad is active low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module modem_line_monitor import uart_pkg::*; #(
  parameter int LINE = 0
) (
  input  logic clk,
  input  logic wb_rst_i,
  input  logic pad_i,
  input  mcr_t mcr_i,
  input  logic msr_rd_i,
  output logic status_o,  // registered effective line
  output logic delta_o    // sticky change flag
);

  logic       sync_q1;
  logic       sync_q2;
  logic [3:0] lb_src;     // loopback sources in line order
  logic       line_eff;

  assign lb_src   = {mcr_i.out2, mcr_i.out1, mcr_i.dtr, mcr_i.rts};
  assign line_eff = mcr_i.loop ? lb_src[LINE] : ~sync_q2;

  // two-flop synchronizer, idles high like an inactive pad
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
    end else begin
      sync_q1 <= pad_i;
      sync_q2 <= sync_q1;
    end
  end

  // status doubles as the delayed copy for change detection
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      status_o <= 1'b0;
      delta_o  <= 1'b0;
    end else begin
      status_o <= line_eff;
      if (msr_rd_i) delta_o <= 1'b0;  // read clears
      else          delta_o <= delta_o || (line_eff != status_o);
    end
  end

endmodule

// ==== logic/uart_reg_bank.sv ====
//////////////////////////////////////////////////////////////////////
// writes land on the next clk edge, reads are combinational
// no FIFO behind addr 0, so it reads zero unless DLAB is set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_reg_bank import uart_pkg::*; (
  input  logic         clk,
  input  logic         wb_rst_i,
  input  reg_addr_t    wb_addr_i,
  input  reg_data_t    wb_dat_i,
  input  logic         wb_we_i,
  input  logic         wb_re_i,
  output reg_data_t    wb_dat_o,
  input  modem_lines_t line_status_i,
  input  modem_lines_t line_delta_i,
  input  logic         ms_pending_i,
  output mcr_t         mcr_o,
  output divisor_t     dl_o,
  output logic         dl_lo_wr_o,
  output logic         ier_ms_o,
  output logic         msr_rd_o
);

  reg_data_t  lcr;
  logic [3:0] ier;      // only the low nibble exists
  reg_data_t  scratch;
  logic       dlab;
  logic       msr_read;

  assign dlab     = lcr[`UART_LCR_DLAB];
  assign ier_ms_o = ier[`UART_IER_MS];
  assign msr_read = wb_re_i && (wb_addr_i == `UART_REG_MS);

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      lcr        <= `UART_LCR_RESET;
      ier        <= '0;
      dl_o       <= '0;
      mcr_o      <= '0;
      scratch    <= '0;
      dl_lo_wr_o <= 1'b0;
    end else begin
      dl_lo_wr_o <= 1'b0;  // single cycle unless rewritten
      if (wb_we_i) begin
        case (wb_addr_i)
          `UART_REG_RB_TR: begin
            if (dlab) begin
              dl_o[7:0]  <= wb_dat_i;
              dl_lo_wr_o <= 1'b1;  // restart baud counter
            end
          end
          `UART_REG_IE: begin
            if (dlab) dl_o[15:8] <= wb_dat_i;
            else      ier        <= wb_dat_i[3:0];
          end
          `UART_REG_LC: lcr     <= wb_dat_i;
          `UART_REG_MC: mcr_o   <= wb_dat_i[4:0];  // upper bits dropped
          `UART_REG_SR: scratch <= wb_dat_i;
          default: ;  // FCR and the rest are not kept
        endcase
      end
    end
  end

  // msr read pulse, also fires once out of reset to flush deltas
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      msr_rd_o <= 1'b1;
    end else begin
      msr_rd_o <= msr_read;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_addr_i)
      `UART_REG_RB_TR: wb_dat_o = dlab ? dl_o[7:0] : 8'h00;
      `UART_REG_IE:    wb_dat_o = dlab ? dl_o[15:8] : {4'h0, ier};
      `UART_REG_II:    wb_dat_o = {`UART_IIR_FIXED,
                                   ms_pending_i ? `UART_IIR_MS : `UART_IIR_NONE};
      `UART_REG_LC:    wb_dat_o = lcr;
      `UART_REG_MC:    wb_dat_o = {3'b000, mcr_o};
      `UART_REG_LS:    wb_dat_o = 8'h00;  // no line status here
      `UART_REG_MS:    wb_dat_o = {line_status_i, line_delta_i};  // state high, deltas low
      `UART_REG_SR:    wb_dat_o = scratch;
    endcase
  end

endmodule

// ==== logic/uart_baud_gen.sv ====
//////////////////////////////////////////////////////////////////////
// one-cycle enable every DL clocks, silent while DL is zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_baud_gen import uart_pkg::*; (
  input  logic     clk,
  input  logic     wb_rst_i,
  input  divisor_t dl_i,
  input  logic     dl_lo_wr_i,
  output logic     baud_o
);

  divisor_t dlc;  // down counter
  logic     dlc_zero;

  assign dlc_zero = (dlc == '0);

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dlc <= '0;
    end else if (dl_lo_wr_i || dlc_zero) begin
      dlc <= dl_i - divisor_t'(1);  // preset, wraps when DL is 0
    end else begin
      dlc <= dlc - divisor_t'(1);
    end
  end

  // pulse when count hits zero, gated off for DL of 0
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      baud_o <= 1'b0;
    end else begin
      baud_o <= dlc_zero && (dl_i != '0);
    end
  end

endmodule

// ==== logic/uart_int_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// modem-status interrupt only, int_o trails the pending flag by 1
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_int_ctrl import uart_pkg::*; (
  input  logic         clk,
  input  logic         wb_rst_i,
  input  logic         ier_ms_i,
  input  modem_lines_t line_delta_i,
  input  logic         msr_rd_i,
  output logic         ms_pending_o,
  output logic         int_o
);

  logic ms_cond;    // enabled and some delta up
  logic ms_cond_d;
  logic ms_rise;

  assign ms_cond = ier_ms_i && (|line_delta_i);
  assign ms_rise = ms_cond && !ms_cond_d;

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ms_cond_d    <= 1'b0;
      ms_pending_o <= 1'b0;
      int_o        <= 1'b0;
    end else begin
      ms_cond_d <= ms_cond;
      // msr read wins, then rise; masking by IER drops it
      if (msr_rd_i)     ms_pending_o <= 1'b0;
      else if (ms_rise) ms_pending_o <= 1'b1;
      else              ms_pending_o <= ms_pending_o && ier_ms_i;
      int_o <= ms_pending_o;
    end
  end

endmodule

// ==== logic/uart_regs_top.sv ====
//////////////////////////////////////////////////////////////////////
// control side of a 16550-style UART, no transmitter or receiver
// modem pads are active low and synchronized inside
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_regs_top import uart_pkg::*; (
  input  logic         clk,
  input  logic         wb_rst_i,
  input  reg_addr_t    wb_addr_i,
  input  reg_data_t    wb_dat_i,
  input  logic         wb_we_i,
  input  logic         wb_re_i,
  output reg_data_t    wb_dat_o,
  input  modem_lines_t modem_pads_i,
  output logic         rts_pad_o,
  output logic         dtr_pad_o,
  output logic         int_o,
  output logic         baud_o
);

  mcr_t              mcr;
  divisor_t          dl;
  logic              dl_lo_wr;
  logic              ier_ms;
  logic              msr_rd;
  logic              ms_pending;
  wire modem_lines_t line_status;  // one bit per monitor
  wire modem_lines_t line_delta;

  assign rts_pad_o = mcr.rts;
  assign dtr_pad_o = mcr.dtr;

  uart_reg_bank uart_reg_bank_inst (
    .clk          (clk),
    .wb_rst_i     (wb_rst_i),
    .wb_addr_i    (wb_addr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_re_i      (wb_re_i),
    .wb_dat_o     (wb_dat_o),
    .line_status_i(line_status),
    .line_delta_i (line_delta),
    .ms_pending_i (ms_pending),
    .mcr_o        (mcr),
    .dl_o         (dl),
    .dl_lo_wr_o   (dl_lo_wr),
    .ier_ms_o     (ier_ms),
    .msr_rd_o     (msr_rd)
  );

  uart_baud_gen uart_baud_gen_inst (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .dl_i      (dl),
    .dl_lo_wr_i(dl_lo_wr),
    .baud_o    (baud_o)
  );

  // one monitor per modem line, index picks the loopback source
  for (genvar i = 0; i < `UART_MODEM_LINES; i++) begin : g_line
    modem_line_monitor #(
      .LINE(i)
    ) modem_line_monitor_inst (
      .clk     (clk),
      .wb_rst_i(wb_rst_i),
      .pad_i   (modem_pads_i[i]),
      .mcr_i   (mcr),
      .msr_rd_i(msr_rd),
      .status_o(line_status[i]),
      .delta_o (line_delta[i])
    );
  end

  uart_int_ctrl uart_int_ctrl_inst (
    .clk         (clk),
    .wb_rst_i    (wb_rst_i),
    .ier_ms_i    (ier_ms),
    .line_delta_i(line_delta),
    .msr_rd_i    (msr_rd),
    .ms_pending_o(ms_pending),
    .int_o       (int_o)
  );

endmodule

// ==== testbench/uart_regs_properties.sv ====
//////////////////////////////////////////////////////////////////////
// bound to uart_regs_top; the baud check assumes DL is 0 or 2 and up
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_regs_properties (
  input logic clk,
  input logic wb_rst_i,
  input logic baud_i,
  input logic int_i,
  input logic ier_ms_i,
  input logic msr_rd_i
);

  // enable is a single-cycle strobe
  baud_single: assert property (@(posedge clk) disable iff (wb_rst_i)
    baud_i |=> !baud_i)
    else $error("baud_o high on two cycles in a row");

  // pending drops on the mask, int_o a cycle later
  int_masked: assert property (@(posedge clk) disable iff (wb_rst_i)
    (!ier_ms_i && $past(!ier_ms_i)) |=> !int_i)
    else $error("int_o high with IER MS clear for two cycles");

  msr_rd_pulse: assert property (@(posedge clk) disable iff (wb_rst_i)
    msr_rd_i |=> !msr_rd_i)
    else $error("msr_rd longer than one cycle");

endmodule

bind uart_regs_top uart_regs_properties uart_regs_properties_inst (
  .clk     (clk),
  .wb_rst_i(wb_rst_i),
  .baud_i  (baud_o),
  .int_i   (int_o),
  .ier_ms_i(ier_ms),
  .msr_rd_i(msr_rd)
);

// ==== testbench/tb_uart_regs.sv ====
//////////////////////////////////////////////////////////////////////
// directed tests, pads idle high; DL kept 0 or at least 2
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module tb_uart_regs import uart_pkg::*; ();

  localparam int WAIT_LIMIT    = 200;  // cycles before a wait gives up
  localparam int COND_BAUD     = 0;
  localparam int COND_INT_HIGH = 1;
  localparam int COND_INT_LOW  = 2;
  localparam int COND_DELTA    = 3;    // delta bit of one line in MSR
  localparam reg_data_t DLAB_SET = `UART_LCR_RESET | (8'h01 << `UART_LCR_DLAB);

  logic       clk;
  logic       wb_rst_i;
  reg_addr_t  wb_addr_i;
  reg_data_t  wb_dat_i;
  logic       wb_we_i;
  logic       wb_re_i;
  reg_data_t  wb_dat_o;
  logic [3:0] pads;  // active low, dcd ri dsr cts
  logic       rts_pad_o;
  logic       dtr_pad_o;
  logic       int_o;
  logic       baud_o;

  uart_regs_top uart_regs_top_inst (
    .clk         (clk),
    .wb_rst_i    (wb_rst_i),
    .wb_addr_i   (wb_addr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_we_i     (wb_we_i),
    .wb_re_i     (wb_re_i),
    .wb_dat_o    (wb_dat_o),
    .modem_pads_i(pads),
    .rts_pad_o   (rts_pad_o),
    .dtr_pad_o   (dtr_pad_o),
    .int_o       (int_o),
    .baud_o      (baud_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // bus and check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive point after the edge
  endtask

  task automatic check_value(input string name, input reg_data_t actual,
                             input reg_data_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Verification failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_we_i   = 1'b1;
    next_cycle();
    wb_we_i   = 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    wb_addr_i = addr;
    wb_re_i   = 1'b1;
    #1;
    data = wb_dat_o;  // combinational mux, settled mid cycle
    next_cycle();
    wb_re_i = 1'b0;
  endtask

  // mux only, no strobe, so MSR deltas survive
  task automatic peek_reg(input reg_addr_t addr, output reg_data_t data);
    wb_addr_i = addr;
    #1;
    data = wb_dat_o;
  endtask

  task automatic wait_for(input int cond, input logic [1:0] line, input string what,
                          output int cycles);
    reg_data_t  msr;
    logic [3:0] delta;
    logic       hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit) begin
      case (cond)
        COND_BAUD:     hit = baud_o;
        COND_INT_HIGH: hit = int_o;
        COND_INT_LOW:  hit = !int_o;
        default: begin
          peek_reg(`UART_REG_MS, msr);
          delta = msr[3:0];
          hit   = delta[line];
        end
      endcase
      if (!hit) begin
        if (cycles == WAIT_LIMIT) begin
          $display("timed out after %0d cycles waiting for %s", cycles, what);
          $display("Verification failed");
          $fatal(1, "wait timed out");
        end
        cycles++;
        next_cycle();
      end
    end
    if (cond == COND_DELTA) next_cycle();  // back to the drive point
  endtask

  // low, high, then low again so the counter reloads with the full value
  task automatic set_divisor(input divisor_t dl);
    bus_write(`UART_REG_LC, DLAB_SET);
    bus_write(`UART_REG_RB_TR, dl[7:0]);
    bus_write(`UART_REG_IE, dl[15:8]);
    bus_write(`UART_REG_RB_TR, dl[7:0]);
    bus_write(`UART_REG_LC, `UART_LCR_RESET);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_defaults();
    reg_data_t data;
    bus_read(`UART_REG_LC, data);
    check_value("lcr", data, `UART_LCR_RESET);
    bus_read(`UART_REG_IE, data);
    check_value("ier", data, 8'h00);
    bus_read(`UART_REG_MC, data);
    check_value("mcr", data, 8'h00);
    bus_read(`UART_REG_SR, data);
    check_value("scratch", data, 8'h00);
    bus_read(`UART_REG_MS, data);
    check_value("msr", data, 8'h00);  // idle pads, no deltas
    bus_read(`UART_REG_II, data);
    check_value("iir", data, {`UART_IIR_FIXED, `UART_IIR_NONE});
    check_value("int_o", reg_data_t'(int_o), 8'h00);
    check_value("baud_o", reg_data_t'(baud_o), 8'h00);
    check_value("rts_pad_o dtr_pad_o", reg_data_t'({rts_pad_o, dtr_pad_o}), 8'h00);
  endtask

  task automatic register_readback();
    reg_data_t value;
    reg_data_t data;
    reg_data_t dl_lo;
    reg_data_t dl_hi;
    value = reg_data_t'($urandom);
    bus_write(`UART_REG_LC, value);
    bus_read(`UART_REG_LC, data);
    check_value("lcr", data, value);
    bus_write(`UART_REG_LC, `UART_LCR_RESET);
    value = reg_data_t'($urandom);
    bus_write(`UART_REG_SR, value);
    bus_read(`UART_REG_SR, data);
    check_value("scratch", data, value);
    value = reg_data_t'($urandom);
    bus_write(`UART_REG_IE, value);
    bus_read(`UART_REG_IE, data);
    check_value("ier", data, {4'h0, value[3:0]});  // low nibble only
    bus_write(`UART_REG_IE, 8'h00);
    dl_hi = reg_data_t'($urandom) | 8'h01;  // high byte first, DL stays large
    dl_lo = reg_data_t'($urandom);
    bus_write(`UART_REG_LC, DLAB_SET);
    bus_write(`UART_REG_IE, dl_hi);
    bus_write(`UART_REG_RB_TR, dl_lo);
    bus_read(`UART_REG_RB_TR, data);
    check_value("dl low", data, dl_lo);
    bus_read(`UART_REG_IE, data);
    check_value("dl high", data, dl_hi);
    bus_write(`UART_REG_LC, `UART_LCR_RESET);
    bus_read(`UART_REG_RB_TR, data);
    check_value("rbr", data, 8'h00);
    value = reg_data_t'($urandom) & 8'h0F;  // loop stays off
    bus_write(`UART_REG_MC, value);
    bus_read(`UART_REG_MC, data);
    check_value("mcr", data, value);
    check_value("rts_pad_o", reg_data_t'(rts_pad_o), reg_data_t'(value[1]));
    check_value("dtr_pad_o", reg_data_t'(dtr_pad_o), reg_data_t'(value[0]));
  endtask

  task automatic baud_spacing();
    divisor_t dl;
    int       cycles;
    int       count;
    dl = divisor_t'($urandom_range(9, 2));
    set_divisor(dl);
    wait_for(COND_BAUD, 2'd0, "first baud pulse", cycles);
    repeat (2) begin
      next_cycle();
      wait_for(COND_BAUD, 2'd0, "next baud pulse", cycles);
      check_value("baud gap", reg_data_t'(cycles + 1), reg_data_t'(dl));
    end
    set_divisor('0);
    count = 0;
    repeat (50) begin
      if (baud_o) count++;
      next_cycle();
    end
    check_value("baud pulses at DL 0", reg_data_t'(count), 8'h00);
  endtask

  task automatic modem_delta();
    logic [1:0] line;
    reg_data_t  data;
    int         cycles;
    line = 2'($urandom);
    repeat (2) begin  // falling then rising pad
      pads[line] = ~pads[line];
      wait_for(COND_DELTA, line, "msr delta", cycles);
      bus_read(`UART_REG_MS, data);
      check_value("msr", data, {~pads, 4'b0001 << line});
      repeat (2) next_cycle();
      peek_reg(`UART_REG_MS, data);
      check_value("msr after read", data, {~pads, 4'h0});
      next_cycle();
    end
  endtask

  task automatic ms_interrupt();
    logic [1:0] line;
    reg_data_t  data;
    int         cycles;
    line = 2'($urandom);
    bus_write(`UART_REG_IE, 8'h01 << `UART_IER_MS);
    pads[line] = ~pads[line];
    wait_for(COND_INT_HIGH, line, "int_o to rise", cycles);
    bus_read(`UART_REG_II, data);
    check_value("iir", data, {`UART_IIR_FIXED, `UART_IIR_MS});
    bus_read(`UART_REG_MS, data);  // clears pending
    wait_for(COND_INT_LOW, line, "int_o to fall", cycles);
    bus_read(`UART_REG_II, data);
    check_value("iir", data, {`UART_IIR_FIXED, `UART_IIR_NONE});
    bus_write(`UART_REG_IE, 8'h00);
    pads[line] = ~pads[line];  // masked change
    wait_for(COND_DELTA, line, "msr delta", cycles);
    repeat (2) next_cycle();  // past the point an unmasked int_o would rise
    check_value("int_o masked", reg_data_t'(int_o), 8'h00);
    bus_read(`UART_REG_MS, data);
  endtask

  task automatic loopback_status();
    reg_data_t  mcr;
    reg_data_t  data;
    logic [3:0] lines;
    mcr   = reg_data_t'($urandom_range(14, 1)) | 8'h10;  // loop on, lines mixed
    lines = {mcr[3], mcr[2], mcr[0], mcr[1]};  // out2 out1 dtr rts
    bus_write(`UART_REG_MC, mcr);
    next_cycle();  // status trails MCR by one
    bus_read(`UART_REG_MS, data);
    check_value("msr status in loopback", data & 8'hF0, {lines, 4'h0});
    pads = ~pads;
    repeat (4) next_cycle();
    bus_read(`UART_REG_MS, data);
    check_value("msr with pads ignored", data, {lines, 4'h0});
  endtask

  initial begin
    void'($urandom(32'hf9b6_b8df));
    clk       = 1'b0;
    wb_rst_i  = 1'b1;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_re_i   = 1'b0;
    pads      = 4'hF;  // all lines inactive
    repeat (3) @(posedge clk);
    #1;
    wb_rst_i = 1'b0;
    reset_defaults();
    register_readback();
    baud_spacing();
    modem_delta();
    ms_interrupt();
    loopback_status();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+common
common/uart_pkg.sv
modem/modem_line_monitor.sv
logic/uart_reg_bank.sv
logic/uart_baud_gen.sv
logic/uart_int_ctrl.sv
logic/uart_regs_top.sv
testbench/uart_regs_properties.sv
testbench/tb_uart_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the UART register testbench with Verilator
# nonzero exit when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_uart_regs \
  -f sources.f \
  -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vtb_uart_regs
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit "$sim_status"
fi

exit 0
